// File: hdl/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter (
    input  ooo_pkg::cdb_t req0_i,
    input  ooo_pkg::cdb_t req1_i,
    output logic          grant0_o,
    output logic          grant1_o,
    output ooo_pkg::cdb_t cdb_o
);
    // station 0 always wins a tie
    assign grant0_o = req0_i.valid;
    assign grant1_o = req1_i.valid && !req0_i.valid;

    always_comb begin
        if (grant0_o) begin
            cdb_o = req0_i;
        end else if (grant1_o) begin
            cdb_o = req1_i;
        end else begin
            // idle bus
            cdb_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatch.sv
`default_nettype none

module dispatch (
    input  wire                 uop_valid_i,
    input  ooo_pkg::uop_t       uop_i,
    output logic                uop_ready_o,
    output ooo_pkg::reg_idx_t   src1_o,
    output ooo_pkg::reg_idx_t   src2_o,
    input  ooo_pkg::operand_t   rf_op1_i,
    input  ooo_pkg::operand_t   rf_op2_i,
    output ooo_pkg::rob_tag_t   rob_query1_o,
    output ooo_pkg::rob_tag_t   rob_query2_o,
    input  wire                 rob_done1_i,
    input  wire                 rob_done2_i,
    input  wire [31:0]          rob_value1_i,
    input  wire [31:0]          rob_value2_i,
    input  ooo_pkg::cdb_t       cdb_i,
    input  wire                 rob_full_i,
    input  ooo_pkg::rob_tag_t   rob_tail_i,
    output logic                alloc_o,
    output ooo_pkg::reg_idx_t   alloc_rd_o,
    input  wire [1:0]           rs_free_i,
    output logic [1:0]          rs_load_o,
    output ooo_pkg::rs_entry_t  rs_entry_o
);
    import ooo_pkg::*;

    // register file first, then a finished rob entry, then this cycle's bus
    function automatic operand_t resolve(operand_t rf, logic done, logic [31:0] rob_value,
                                         cdb_t cdb);
        operand_t op;
        op = rf;
        if (!rf.valid) begin
            if (done) begin
                op.valid = 1'b1;
                op.value = rob_value;
            end else if (cdb.valid && cdb.tag == rf.tag) begin
                op.valid = 1'b1;
                op.value = cdb.data;
            end
        end
        return op;
    endfunction

    assign src1_o       = uop_i.rs1;
    assign src2_o       = uop_i.rs2;
    assign rob_query1_o = rf_op1_i.tag;
    assign rob_query2_o = rf_op2_i.tag;

    assign uop_ready_o = !rob_full_i && (rs_free_i != 2'b00);
    assign alloc_o     = uop_valid_i && uop_ready_o;
    assign alloc_rd_o  = uop_i.rd;

    // station 0 preferred, station 1 only when 0 is full
    assign rs_load_o[0] = alloc_o && rs_free_i[0];
    assign rs_load_o[1] = alloc_o && !rs_free_i[0];

    always_comb begin
        rs_entry_o.op      = uop_i.op;
        rs_entry_o.dst_tag = rob_tail_i;
        rs_entry_o.src1    = resolve(rf_op1_i, rob_done1_i, rob_value1_i, cdb_i);
        if (uop_i.use_imm) begin
            rs_entry_o.src2.valid = 1'b1;
            rs_entry_o.src2.tag   = '0;
            rs_entry_o.src2.value = uop_i.imm;
        end else begin
            rs_entry_o.src2 = resolve(rf_op2_i, rob_done2_i, rob_value2_i, cdb_i);
        end
    end

endmodule

`default_nettype wire

// File: hdl/ooo_core.sv
`default_nettype none

module ooo_core (
    input  wire              clk,
    input  wire              arst_n_i,
    input  wire              uop_valid_i,
    input  ooo_pkg::uop_t    uop_i,
    output logic             uop_ready_o,
    output logic             commit_valid_o,
    output ooo_pkg::commit_t commit_o,
    input  wire              commit_ready_i
);
    import ooo_pkg::*;

    reg_idx_t    src1;
    reg_idx_t    src2;
    operand_t    rf_op1;
    operand_t    rf_op2;
    rob_tag_t    rob_query1;
    rob_tag_t    rob_query2;
    logic        rob_done1;
    logic        rob_done2;
    logic [31:0] rob_value1;
    logic [31:0] rob_value2;
    logic        rob_full;
    rob_tag_t    rob_tail;
    rob_tag_t    rob_head;
    logic        alloc;
    reg_idx_t    alloc_rd;
    logic [1:0]  rs_free;
    logic [1:0]  rs_load;
    rs_entry_t   rs_entry;
    cdb_t        req0;
    cdb_t        req1;
    logic        grant0;
    logic        grant1;
    cdb_t        cdb;

    dispatch dispatch (
        .uop_valid_i (uop_valid_i),
        .uop_i       (uop_i),
        .uop_ready_o (uop_ready_o),
        .src1_o      (src1),
        .src2_o      (src2),
        .rf_op1_i    (rf_op1),
        .rf_op2_i    (rf_op2),
        .rob_query1_o(rob_query1),
        .rob_query2_o(rob_query2),
        .rob_done1_i (rob_done1),
        .rob_done2_i (rob_done2),
        .rob_value1_i(rob_value1),
        .rob_value2_i(rob_value2),
        .cdb_i       (cdb),
        .rob_full_i  (rob_full),
        .rob_tail_i  (rob_tail),
        .alloc_o     (alloc),
        .alloc_rd_o  (alloc_rd),
        .rs_free_i   (rs_free),
        .rs_load_o   (rs_load),
        .rs_entry_o  (rs_entry)
    );

    // head retires into the registers on the commit handshake
    regfile regfile (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .src1_i       (src1),
        .src2_i       (src2),
        .op1_o        (rf_op1),
        .op2_o        (rf_op2),
        .alloc_i      (alloc),
        .alloc_rd_i   (alloc_rd),
        .alloc_tag_i  (rob_tail),
        .commit_i     (commit_valid_o & commit_ready_i),
        .commit_tag_i (rob_head),
        .commit_data_i(commit_o)
    );

    rob rob (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .alloc_i       (alloc),
        .alloc_rd_i    (alloc_rd),
        .tail_o        (rob_tail),
        .full_o        (rob_full),
        .cdb_i         (cdb),
        .query1_i      (rob_query1),
        .query2_i      (rob_query2),
        .done1_o       (rob_done1),
        .done2_o       (rob_done2),
        .value1_o      (rob_value1),
        .value2_o      (rob_value2),
        .commit_valid_o(commit_valid_o),
        .commit_o      (commit_o),
        .head_o        (rob_head),
        .commit_ready_i(commit_ready_i)
    );

    reservation_station rs0 (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .load_i  (rs_load[0]),
        .entry_i (rs_entry),
        .free_o  (rs_free[0]),
        .cdb_i   (cdb),
        .req_o   (req0),
        .grant_i (grant0)
    );

    reservation_station rs1 (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .load_i  (rs_load[1]),
        .entry_i (rs_entry),
        .free_o  (rs_free[1]),
        .cdb_i   (cdb),
        .req_o   (req1),
        .grant_i (grant1)
    );

    cdb_arbiter cdb_arbiter (
        .req0_i  (req0),
        .req1_i  (req1),
        .grant0_o(grant0),
        .grant1_o(grant1),
        .cdb_o   (cdb)
    );

endmodule

`default_nettype wire

// File: hdl/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// architectural registers, index is 4 bits
`define OOO_NUM_REGS 16

// reorder buffer entries, one tag per entry
`define OOO_ROB_DEPTH 8

// entries in each reservation station
`define OOO_RS_DEPTH 4

`endif

// File: hdl/ooo_pkg.sv
`default_nettype none

`include "ooo_params.svh"

package ooo_pkg;

    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

    // shifts take the low 5 bits of b, slt is signed
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_t;

    typedef struct packed {
        alu_op_t     op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic        use_imm;
        logic [31:0] imm;
    } uop_t;

    // value is only meaningful when valid, otherwise wait on tag
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] value;
    } operand_t;

    typedef struct packed {
        alu_op_t  op;
        rob_tag_t dst_tag;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] data;
    } cdb_t;

    typedef struct packed {
        reg_idx_t    rd;
        logic [31:0] data;
    } commit_t;

endpackage

`default_nettype wire

// File: hdl/regfile.sv
`default_nettype none

`include "ooo_params.svh"

module regfile (
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  ooo_pkg::reg_idx_t   src1_i,
    input  ooo_pkg::reg_idx_t   src2_i,
    output ooo_pkg::operand_t   op1_o,
    output ooo_pkg::operand_t   op2_o,
    input  wire                 alloc_i,
    input  ooo_pkg::reg_idx_t   alloc_rd_i,
    input  ooo_pkg::rob_tag_t   alloc_tag_i,
    input  wire                 commit_i,
    input  ooo_pkg::rob_tag_t   commit_tag_i,
    input  ooo_pkg::commit_t    commit_data_i
);
    import ooo_pkg::*;

    logic [31:0]              value_q [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] busy_q;
    rob_tag_t                 tag_q [`OOO_NUM_REGS];

    // r0 is never allocated or written, so it reads as ready zero
    function automatic operand_t read_reg(reg_idx_t idx);
        operand_t op;
        op.valid = ~busy_q[idx];
        op.tag   = tag_q[idx];
        op.value = value_q[idx];
        return op;
    endfunction

    always_comb begin
        op1_o = read_reg(src1_i);
        op2_o = read_reg(src2_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (commit_i) begin
                if (commit_data_i.rd != '0) begin
                    value_q[commit_data_i.rd] <= commit_data_i.data;
                end
                // a younger producer keeps the register busy
                if (tag_q[commit_data_i.rd] == commit_tag_i) begin
                    busy_q[commit_data_i.rd] <= 1'b0;
                end
            end
            // allocation comes last so it wins over a same-edge commit
            if (alloc_i && alloc_rd_i != '0) begin
                busy_q[alloc_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i && alloc_rd_i != '0) begin
            tag_q[alloc_rd_i] <= alloc_tag_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reservation_station.sv
`default_nettype none

`include "ooo_params.svh"

module reservation_station (
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  wire                 load_i,
    input  ooo_pkg::rs_entry_t  entry_i,
    output logic                free_o,
    input  ooo_pkg::cdb_t       cdb_i,
    output ooo_pkg::cdb_t       req_o,
    input  wire                 grant_i
);
    import ooo_pkg::*;

    localparam int depth = `OOO_RS_DEPTH;
    localparam int idx_w = $clog2(depth);
    // no entry outlives a full rob of allocations, so this width never wraps onto a live one
    localparam int stamp_w = $clog2(`OOO_ROB_DEPTH) + 1;

    rs_entry_t          entry_q [depth];
    logic [stamp_w-1:0] stamp_q [depth];
    logic [depth-1:0]   busy_q;
    logic [stamp_w-1:0] alloc_cnt_q;

    logic               res_valid_q;
    rob_tag_t           res_tag_q;
    logic [31:0]        res_data_q;

    logic [idx_w-1:0]   load_idx;
    logic [idx_w-1:0]   issue_idx;
    logic               issue_ok;
    logic               can_issue;
    logic [stamp_w-1:0] best_age;
    logic [stamp_w-1:0] cur_age;
    logic [31:0]        alu_result;

    function automatic logic [31:0] alu_exec(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            default: return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    // lowest free slot takes the next load
    always_comb begin
        free_o   = 1'b0;
        load_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_o   = 1'b1;
                load_idx = idx_w'(i);
            end
        end
    end

    // oldest ready entry, age counted in allocations since it arrived
    always_comb begin
        issue_ok  = 1'b0;
        issue_idx = '0;
        best_age  = '0;
        cur_age   = '0;
        for (int i = 0; i < depth; i++) begin
            cur_age = alloc_cnt_q - stamp_q[i];
            if (busy_q[i] && entry_q[i].src1.valid && entry_q[i].src2.valid &&
                (!issue_ok || cur_age > best_age)) begin
                issue_ok  = 1'b1;
                issue_idx = idx_w'(i);
                best_age  = cur_age;
            end
        end
    end

    // stall while an ungranted result is still held
    assign can_issue  = issue_ok && (!res_valid_q || grant_i);
    assign alu_result = alu_exec(entry_q[issue_idx].op, entry_q[issue_idx].src1.value,
                                 entry_q[issue_idx].src2.value);

    always_comb begin
        req_o.valid = res_valid_q;
        req_o.tag   = res_tag_q;
        req_o.data  = res_data_q;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= '0;
            alloc_cnt_q <= '0;
            res_valid_q <= 1'b0;
        end else begin
            if (can_issue) begin
                busy_q[issue_idx] <= 1'b0;
                res_valid_q       <= 1'b1;
            end else if (grant_i) begin
                res_valid_q <= 1'b0;
            end
            if (load_i) begin
                busy_q[load_idx] <= 1'b1;
                alloc_cnt_q      <= alloc_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // capture waiting operands off the bus
        for (int i = 0; i < depth; i++) begin
            if (busy_q[i] && cdb_i.valid) begin
                if (!entry_q[i].src1.valid && entry_q[i].src1.tag == cdb_i.tag) begin
                    entry_q[i].src1.valid <= 1'b1;
                    entry_q[i].src1.value <= cdb_i.data;
                end
                if (!entry_q[i].src2.valid && entry_q[i].src2.tag == cdb_i.tag) begin
                    entry_q[i].src2.valid <= 1'b1;
                    entry_q[i].src2.value <= cdb_i.data;
                end
            end
        end
        if (load_i) begin
            entry_q[load_idx] <= entry_i;
            stamp_q[load_idx] <= alloc_cnt_q;
        end
        if (can_issue) begin
            res_tag_q  <= entry_q[issue_idx].dst_tag;
            res_data_q <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob.sv
`default_nettype none

`include "ooo_params.svh"

module rob (
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  wire                 alloc_i,
    input  ooo_pkg::reg_idx_t   alloc_rd_i,
    output ooo_pkg::rob_tag_t   tail_o,
    output logic                full_o,
    input  ooo_pkg::cdb_t       cdb_i,
    input  ooo_pkg::rob_tag_t   query1_i,
    input  ooo_pkg::rob_tag_t   query2_i,
    output logic                done1_o,
    output logic                done2_o,
    output logic [31:0]         value1_o,
    output logic [31:0]         value2_o,
    output logic                commit_valid_o,
    output ooo_pkg::commit_t    commit_o,
    output ooo_pkg::rob_tag_t   head_o,
    input  wire                 commit_ready_i
);
    import ooo_pkg::*;

    localparam int depth = `OOO_ROB_DEPTH;
    localparam int cnt_w = $clog2(depth + 1);

    reg_idx_t         rd_q [depth];
    logic [31:0]      value_q [depth];
    logic [depth-1:0] done_q;
    rob_tag_t         head_q;
    rob_tag_t         tail_q;
    logic [cnt_w-1:0] count_q;
    logic             commit_fire;

    assign tail_o = tail_q;
    assign head_o = head_q;
    assign full_o = (count_q == cnt_w'(depth));

    // operand lookups from dispatch
    assign done1_o  = done_q[query1_i];
    assign done2_o  = done_q[query2_i];
    assign value1_o = value_q[query1_i];
    assign value2_o = value_q[query2_i];

    assign commit_valid_o = (count_q != '0) && done_q[head_q];
    assign commit_o.rd    = rd_q[head_q];
    assign commit_o.data  = value_q[head_q];
    assign commit_fire    = commit_valid_o && commit_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            // bus never carries the free tail or the done head
            if (cdb_i.valid) begin
                done_q[cdb_i.tag] <= 1'b1;
            end
            if (commit_fire) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            case ({alloc_i, commit_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (cdb_i.valid) begin
            value_q[cdb_i.tag] <= cdb_i.data;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/regfile.sv
hdl/rob.sv
hdl/reservation_station.sv
hdl/cdb_arbiter.sv
hdl/dispatch.sv
hdl/ooo_core.sv
tb/ooo_checker.sv
tb/tb_ooo.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_ooo -o tb_ooo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_ooo_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb/ooo_checker.sv
`default_nettype none

`include "ooo_params.svh"

module ooo_checker (
    input  wire              clk,
    input  wire              arst_n_i,
    input  wire              uop_valid_i,
    input  ooo_pkg::uop_t    uop_i,
    input  wire              uop_ready_i,
    input  wire              commit_valid_i,
    input  ooo_pkg::commit_t commit_i,
    input  wire              commit_ready_i,
    output int               errors_o,
    output int               commits_o,
    output int               pending_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import ooo_pkg::*;

    // architectural state of an in-order machine
    logic [31:0] regs [`OOO_NUM_REGS];
    commit_t     exp_q [$];
    int          errors;
    int          commits;

    assign errors_o  = errors;
    assign commits_o = commits;
    assign pending_o = exp_q.size();

    function automatic logic [31:0] expected_result(alu_op_t op, logic [31:0] a,
                                                    logic [31:0] b);
        logic [31:0] res;
        case (op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            SLL:     res = a << b[4:0];
            SRL:     res = a >> b[4:0];
            SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: res = '0;
        endcase
        return res;
    endfunction

    // both ports sampled on the edge where their handshake completes
    always @(posedge clk) begin : watch_ports
        commit_t     exp;
        logic [31:0] a;
        logic [31:0] b;
        if (!arst_n_i) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] = '0;
            end
            exp_q.delete();
            errors  = 0;
            commits = 0;
        end else begin
            // older work retires before the new micro-op is queued
            if (commit_valid_i && commit_ready_i) begin
                commits++;
                if (exp_q.size() == 0) begin
                    $display("unexpected commit at %0t with no micro-op outstanding", $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (commit_i != exp) begin
                        $display("MISMATCH at %0t: commit %0d got r%0d=%08h, want r%0d=%08h",
                                 $time, commits, commit_i.rd, commit_i.data, exp.rd, exp.data);
                        errors++;
                    end
                end
            end
            if (uop_valid_i && uop_ready_i) begin
                a = regs[uop_i.rs1];
                b = uop_i.use_imm ? uop_i.imm : regs[uop_i.rs2];
                exp.rd   = uop_i.rd;
                exp.data = expected_result(uop_i.op, a, b);
                // r0 stays zero but the commit still carries the result
                if (uop_i.rd != '0) begin
                    regs[uop_i.rd] = exp.data;
                end
                exp_q.push_back(exp);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_ooo.sv
`default_nettype none

`include "ooo_params.svh"

module tb_ooo;
    timeunit 1ns;
    timeprecision 1ps;

    import ooo_pkg::*;

    // micro-op flavours
    localparam int kind_indep = 0;
    localparam int kind_chain = 1;
    localparam int kind_zero  = 2;

    // commit_ready behaviour
    localparam int ready_always = 0;
    localparam int ready_random = 1;
    localparam int ready_hold   = 2;

    localparam int total_uops  = 200 + 200 + 100 + 200 + 2 * `OOO_ROB_DEPTH;
    localparam int cycle_limit = 40 * total_uops;

    logic     clk;
    logic     arst_n;
    logic     uop_valid;
    uop_t     uop;
    logic     uop_ready;
    logic     commit_valid;
    commit_t  commit;
    logic     commit_ready;

    int       seed;
    int       ready_mode;
    int       cycles;
    int       tb_errors;
    int       chk_errors;
    int       commits_seen;
    int       pending;
    int       chk_base;
    int       tb_base;
    int       commit_base;
    int       test_num;
    int       tests_passed;
    int       tests_failed;
    int       accepted;
    commit_t  held_commit;
    uop_t     fill_uop;
    reg_idx_t recent [4];

    ooo_core dut0 (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .uop_valid_i   (uop_valid),
        .uop_i         (uop),
        .uop_ready_o   (uop_ready),
        .commit_valid_o(commit_valid),
        .commit_o      (commit),
        .commit_ready_i(commit_ready)
    );

    ooo_checker chk0 (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .uop_valid_i   (uop_valid),
        .uop_i         (uop),
        .uop_ready_i   (uop_ready),
        .commit_valid_i(commit_valid),
        .commit_i      (commit),
        .commit_ready_i(commit_ready),
        .errors_o      (chk_errors),
        .commits_o     (commits_seen),
        .pending_o     (pending)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // commit back-pressure changes on the falling edge like every other input
    always @(negedge clk) begin : drive_commit_ready
        logic [31:0] r;
        case (ready_mode)
            ready_random: begin
                r = $random(seed);
                commit_ready = r[0];
            end
            ready_hold: commit_ready = 1'b0;
            default:    commit_ready = 1'b1;
        endcase
    end

    task automatic make_uop(input int kind, output uop_t u);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        u.op      = alu_op_t'(r1[2:0]);
        u.rd      = r1[6:3];
        u.rs1     = r1[10:7];
        u.rs2     = r1[14:11];
        u.use_imm = r1[15];
        u.imm     = r2;
        if (kind == kind_chain) begin
            // mostly read one of the last four destinations
            if (r1[17:16] != 2'b00) begin
                u.rs1 = recent[r1[19:18]];
            end
            if (r1[21:20] != 2'b00) begin
                u.rs2 = recent[r1[23:22]];
            end
            u.use_imm = r1[24] & r1[25];
        end else if (kind == kind_zero) begin
            if (r1[16]) begin
                u.rd = '0;
            end
            if (r1[17]) begin
                u.rs1 = '0;
            end
            if (r1[18]) begin
                u.rs2 = '0;
            end
        end
        recent[3] = recent[2];
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = u.rd;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_uop(input uop_t u);
        uop_valid = 1'b1;
        uop       = u;
        while (!uop_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic run_stream(input int count, input int kind);
        uop_t u;
        for (int i = 0; i < count; i++) begin
            make_uop(kind, u);
            send_uop(u);
        end
        uop_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending != 0 || commit_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        chk_base    = chk_errors;
        tb_base     = tb_errors;
        commit_base = commits_seen;
    endtask

    task automatic finish_test(input string name, input int sent);
        int commits;
        int errs;
        wait_drain();
        commits = commits_seen - commit_base;
        if (commits != sent) begin
            $display("%s: %0d micro-ops accepted but %0d committed", name, sent, commits);
            tb_errors++;
        end
        errs = (chk_errors - chk_base) + (tb_errors - tb_base);
        test_num++;
        if (errs == 0) begin
            tests_passed++;
            $display("test %0d %s: PASS, %0d commits", test_num, name, commits);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d commits, %0d errors", test_num, name, commits, errs);
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        uop_valid    = 1'b0;
        uop          = '0;
        commit_ready = 1'b1;
        seed         = 40100;
        ready_mode   = ready_always;
        cycles       = 0;
        tb_errors    = 0;
        test_num     = 0;
        tests_passed = 0;
        tests_failed = 0;
        foreach (recent[i]) begin
            recent[i] = '0;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test();
        repeat (4) begin
            @(negedge clk);
            if (commit_valid || !uop_ready) begin
                $display("reset state wrong at %0t: commit_valid %0b, uop_ready %0b",
                         $time, commit_valid, uop_ready);
                tb_errors++;
            end
        end
        finish_test("reset state", 0);

        start_test();
        run_stream(200, kind_indep);
        finish_test("independent alu ops", 200);

        start_test();
        run_stream(200, kind_chain);
        finish_test("dependency chains", 200);

        start_test();
        run_stream(100, kind_zero);
        finish_test("register 0", 100);

        start_test();
        ready_mode = ready_random;
        run_stream(200, kind_chain);
        finish_test("commit back-pressure", 200);

        // hold the head until dispatch stalls on a full rob
        start_test();
        ready_mode = ready_hold;
        repeat (2) @(negedge clk);
        accepted = 0;
        while (uop_ready && accepted < 2 * `OOO_ROB_DEPTH) begin
            make_uop(kind_chain, fill_uop);
            uop_valid = 1'b1;
            uop       = fill_uop;
            @(negedge clk);
            accepted++;
        end
        uop_valid = 1'b0;
        // a finished head must wait unchanged for commit_ready
        held_commit = commit;
        repeat (4) begin
            @(negedge clk);
            if (!commit_valid || commit != held_commit) begin
                $display("queue fill: head not held at %0t while commit_ready was low", $time);
                tb_errors++;
            end
        end
        if (accepted != `OOO_ROB_DEPTH || uop_ready) begin
            $display("queue fill: dispatch accepted %0d micro-ops before stalling, not %0d",
                     accepted, `OOO_ROB_DEPTH);
            tb_errors++;
        end
        ready_mode = ready_always;
        run_stream(`OOO_ROB_DEPTH, kind_chain);
        finish_test("queue fill", accepted + `OOO_ROB_DEPTH);

        $display("tests %0d, passed %0d, failed %0d, commits %0d, errors %0d",
                 test_num, tests_passed, tests_failed, commits_seen, tb_errors + chk_errors);
        if (tests_failed == 0 && tb_errors + chk_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
